// File: verilog/exc_pkg.sv
// ----------------------------------------------------------
// Thread blocks are 256 bytes and IDT entries are 8 bytes
// The IDT always holds 64 entries
// ----------------------------------------------------------
package exc_pkg;

	localparam int WORD_W = 32;
	localparam int IRQ_NUM_W = 7;
	localparam int IDT_ENTRIES = 64;
	localparam int IDT_STRIDE = 8;
	localparam int VECTOR_OFFSET = 4;
	// Wide enough to count up to IDT_ENTRIES
	localparam int CNT_W = $clog2(IDT_ENTRIES + 1);

	// Configuration word of an IDT entry
	localparam int ICT_VALID_BIT = 0;
	localparam int ICT_MASK_BIT = 1;
	localparam int ICT_LEVEL_LSB = 16;

	// Thread state table layout
	localparam int TST_BLOCK_SHIFT = 8;
	localparam int TST_USPR_OFFSET = 8;
	localparam int TST_KSPR_OFFSET = 12;

	localparam int PSR_IE_BIT = 2;
	localparam int PSR_MODE_LSB = 5;

	// Load/store clients on the shared port
	localparam int NUM_CLIENTS = 3;
	localparam int CLIENT_SPR = 0;
	localparam int CLIENT_FETCH = 1;
	localparam int CLIENT_IDT = 2;

	typedef logic [WORD_W-1:0] word_t;

	typedef enum logic [1:0] {
		KERNEL = 2'd0,
		USER = 2'd3
	} core_mode_t;

	typedef enum logic [2:0] {
		IDLE,
		JUMP,
		IRQ_SET,
		IRQ_RET,
		IDT_LOAD
	} seq_state_t;

	typedef struct packed {
		word_t spr;
		word_t tidr;
		word_t tisr;
		word_t psr;
		word_t ppsr;
		word_t ppcr;
		word_t idtr;
	} sysreg_snap_t;

	typedef struct packed {
		logic [5:0] entry;
		logic mask;
		logic valid;
		logic [1:0] level;
	} ict_rec_t;

endpackage

// File: verilog/mem_req_if.sv
// ----------------------------------------------------------
// Every accepted request gets one rvalid later, in order
// ----------------------------------------------------------
`timescale 1ns/1ps

interface mem_req_if
	import exc_pkg::*;
();

	logic req;
	logic busy;
	logic rw;
	word_t addr;
	word_t wdata;
	logic rvalid;
	word_t rdata;

	// Held request keeps rw, addr and wdata stable until accepted
	modport client (
		output req,
		output rw,
		output addr,
		output wdata,
		input busy,
		input rvalid,
		input rdata
	);

	modport arbiter (
		input req,
		input rw,
		input addr,
		input wdata,
		output busy,
		output rvalid,
		output rdata
	);

endinterface

// File: verilog/exc_sequencer.sv
// ----------------------------------------------------------
// One event at a time; system registers are frozen from IDLE
// ----------------------------------------------------------
`timescale 1ns/1ps

module exc_sequencer
	import exc_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic jump,
	input word_t jump_addr,
	input logic irq_ret,
	input logic idt_set,
	input logic irq_req,
	input logic [IRQ_NUM_W-1:0] irq_num,
	input logic irq_lock,
	input word_t spr,
	input word_t tidr,
	input word_t tisr,
	input word_t psr,
	input word_t ppsr,
	input word_t pcr,
	input word_t ppcr_in,
	input word_t idtr,
	output logic swap_start,
	output logic swap_to_kernel,
	output sysreg_snap_t snap,
	input logic swap_done,
	input word_t swap_spr,
	output logic fetch_start,
	output logic [IRQ_NUM_W-1:0] fetch_num,
	input logic fetch_done,
	input word_t fetch_addr,
	output logic load_start,
	input logic load_done,
	output logic pipeline_stop,
	output logic refresh,
	output logic pc_set,
	output word_t pc,
	output logic ppcr_set,
	output word_t ppcr,
	output logic set_irq_mode,
	output logic clr_irq_mode,
	output logic irq_ack,
	output logic spr_write,
	output word_t spr_new
);

	typedef enum logic [1:0] {
		ST_FETCH,
		ST_SWAP,
		ST_DONE
	} step_t;

	seq_state_t state;
	step_t step;
	logic irq_pend;
	logic op_busy;
	logic irq_ok;
	logic snap_user;
	logic ret_user;
	word_t jump_addr_q;

	assign irq_ok = irq_req && psr[PSR_IE_BIT] && !irq_lock;
	assign snap_user = core_mode_t'(snap.psr[PSR_MODE_LSB +: 2]) == USER;
	assign ret_user = core_mode_t'(ppsr[PSR_MODE_LSB +: 2]) == USER;

	// Stall already in the cycle the interrupt is seen
	assign pipeline_stop = (state != IDLE) || (irq_ok && !jump);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= IDLE;
			step <= ST_FETCH;
			irq_pend <= 1'b0;
			op_busy <= 1'b0;
			swap_to_kernel <= 1'b0;
			fetch_start <= 1'b0;
			swap_start <= 1'b0;
			load_start <= 1'b0;
			refresh <= 1'b0;
			pc_set <= 1'b0;
			ppcr_set <= 1'b0;
			set_irq_mode <= 1'b0;
			clr_irq_mode <= 1'b0;
			irq_ack <= 1'b0;
			spr_write <= 1'b0;
		end else begin
			fetch_start <= 1'b0;
			swap_start <= 1'b0;
			load_start <= 1'b0;
			refresh <= 1'b0;
			pc_set <= 1'b0;
			ppcr_set <= 1'b0;
			set_irq_mode <= 1'b0;
			clr_irq_mode <= 1'b0;
			irq_ack <= 1'b0;
			spr_write <= 1'b0;
			if (fetch_done || swap_done || load_done) begin
				op_busy <= 1'b0;
			end else if (fetch_start || swap_start || load_start) begin
				op_busy <= 1'b1;
			end
			case (state)
				IDLE: begin
					// Priority is jump, interrupt, return, IDT set
					if (jump) begin
						state <= JUMP;
						refresh <= 1'b1;
						irq_pend <= irq_req && psr[PSR_IE_BIT];
					end else if (irq_ok) begin
						state <= IRQ_SET;
						step <= ST_FETCH;
						refresh <= 1'b1;
						ppcr_set <= 1'b1;
						set_irq_mode <= 1'b1;
						fetch_start <= 1'b1;
					end else if (irq_ret) begin
						state <= IRQ_RET;
						refresh <= 1'b1;
						if (ret_user) begin
							step <= ST_SWAP;
							swap_start <= 1'b1;
							swap_to_kernel <= 1'b0;
						end else begin
							step <= ST_DONE;
						end
					end else if (idt_set) begin
						state <= IDT_LOAD;
						refresh <= 1'b1;
						load_start <= 1'b1;
					end
				end
				JUMP: begin
					// Pending interrupt saves the branch target as return PC
					if (irq_pend) begin
						state <= IRQ_SET;
						step <= ST_FETCH;
						refresh <= 1'b1;
						ppcr_set <= 1'b1;
						set_irq_mode <= 1'b1;
						fetch_start <= 1'b1;
					end else begin
						state <= IDLE;
						pc_set <= 1'b1;
					end
				end
				IRQ_SET: begin
					case (step)
						ST_FETCH: begin
							if (fetch_done && snap_user) begin
								step <= ST_SWAP;
								swap_start <= 1'b1;
								swap_to_kernel <= 1'b1;
							end else if (fetch_done) begin
								step <= ST_DONE;
							end
						end
						ST_SWAP: begin
							if (swap_done) begin
								spr_write <= 1'b1;
								step <= ST_DONE;
							end
						end
						default: begin
							state <= IDLE;
							pc_set <= 1'b1;
							irq_ack <= 1'b1;
						end
					endcase
				end
				IRQ_RET: begin
					if (step == ST_SWAP) begin
						if (swap_done) begin
							spr_write <= 1'b1;
							step <= ST_DONE;
						end
					end else begin
						state <= IDLE;
						pc_set <= 1'b1;
						clr_irq_mode <= 1'b1;
					end
				end
				IDT_LOAD: begin
					if (load_done) begin
						state <= IDLE;
						pc_set <= 1'b1;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (state == IDLE) begin
			snap <= '{spr, tidr, tisr, psr, ppsr, ppcr_in, idtr};
			fetch_num <= irq_num;
			jump_addr_q <= jump_addr;
			ppcr <= pcr;
		end else if (state == JUMP) begin
			ppcr <= jump_addr_q;
		end
		case (state)
			JUMP, IDT_LOAD: pc <= jump_addr_q;
			IRQ_RET: pc <= snap.ppcr;
			IRQ_SET: begin
				if (fetch_done) begin
					pc <= fetch_addr;
				end
			end
			default: begin
			end
		endcase
		if (swap_done) begin
			spr_new <= swap_spr;
		end
	end

	// Sub-operations never overlap
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		(fetch_start || swap_start || load_start) |->
			!op_busy && $onehot({fetch_start, swap_start, load_start}));

endmodule

// File: verilog/handler_fetch.sv
// ----------------------------------------------------------
// Reads one handler word; irq_num must index a valid IDT entry
// ----------------------------------------------------------
`timescale 1ns/1ps

module handler_fetch
	import exc_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic start,
	input logic [IRQ_NUM_W-1:0] irq_num,
	input word_t idtr,
	output logic done,
	output word_t handler,
	mem_req_if.client mem
);

	logic req_q;
	logic wait_q;
	word_t addr_q;

	assign mem.req = req_q;
	assign mem.rw = 1'b0;
	assign mem.addr = addr_q;
	assign mem.wdata = '0;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			req_q <= 1'b0;
			wait_q <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				req_q <= 1'b1;
			end else if (req_q && !mem.busy) begin
				req_q <= 1'b0;
				wait_q <= 1'b1;
			end
			if (wait_q && mem.rvalid) begin
				wait_q <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		// Vector sits in the second word of the entry
		if (start) begin
			addr_q <= idtr + word_t'(irq_num) * word_t'(IDT_STRIDE) + word_t'(VECTOR_OFFSET);
		end
		if (wait_q && mem.rvalid) begin
			handler <= mem.rdata;
		end
	end

endmodule

// File: verilog/spr_swap.sv
// ----------------------------------------------------------
// Thread block index is the low 14 bits of TIDR
// ----------------------------------------------------------
`timescale 1ns/1ps

module spr_swap
	import exc_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic start,
	input logic to_kernel,
	input word_t spr,
	input word_t tidr,
	input word_t tisr,
	output logic done,
	output word_t new_spr,
	mem_req_if.client mem
);

	typedef enum logic [2:0] {
		S_IDLE,
		S_WR,
		S_WR_WAIT,
		S_RD,
		S_RD_WAIT
	} swap_state_t;

	swap_state_t state;
	logic to_kernel_q;
	word_t block_q;
	word_t spr_q;
	word_t uspr_addr;
	word_t kspr_addr;

	assign uspr_addr = block_q + word_t'(TST_USPR_OFFSET);
	assign kspr_addr = block_q + word_t'(TST_KSPR_OFFSET);

	// Outgoing SPR goes to the slot of the mode being left
	assign mem.req = (state == S_WR) || (state == S_RD);
	assign mem.rw = (state == S_WR);
	assign mem.addr = ((state == S_WR) == to_kernel_q) ? uspr_addr : kspr_addr;
	assign mem.wdata = spr_q;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= S_IDLE;
			to_kernel_q <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				S_IDLE: begin
					if (start) begin
						state <= S_WR;
						to_kernel_q <= to_kernel;
					end
				end
				S_WR: begin
					if (!mem.busy) begin
						state <= S_WR_WAIT;
					end
				end
				// Read only after the write is answered
				S_WR_WAIT: begin
					if (mem.rvalid) begin
						state <= S_RD;
					end
				end
				S_RD: begin
					if (!mem.busy) begin
						state <= S_RD_WAIT;
					end
				end
				default: begin
					if (mem.rvalid) begin
						state <= S_IDLE;
						done <= 1'b1;
					end
				end
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (start) begin
			block_q <= tisr + (word_t'(tidr[13:0]) << TST_BLOCK_SHIFT);
			spr_q <= spr;
		end
		if (state == S_RD_WAIT && mem.rvalid) begin
			new_spr <= mem.rdata;
		end
	end

	assert property (@(posedge iCLOCK) disable iff (!inRESET) start |-> state == S_IDLE);

endmodule

// File: verilog/idt_loader.sv
// ----------------------------------------------------------
// Reads all 64 entries with several reads in flight
// ----------------------------------------------------------
`timescale 1ns/1ps

module idt_loader
	import exc_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic start,
	input word_t idtr,
	output logic done,
	output logic ict_write,
	output ict_rec_t ict,
	mem_req_if.client mem
);

	logic active;
	logic [CNT_W-1:0] issue_cnt;
	logic [CNT_W-1:0] resp_cnt;
	word_t base_q;

	assign mem.req = active && (issue_cnt != CNT_W'(IDT_ENTRIES));
	assign mem.rw = 1'b0;
	assign mem.addr = base_q + word_t'(issue_cnt) * word_t'(IDT_STRIDE);
	assign mem.wdata = '0;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			active <= 1'b0;
			issue_cnt <= '0;
			resp_cnt <= '0;
			done <= 1'b0;
			ict_write <= 1'b0;
		end else begin
			done <= 1'b0;
			ict_write <= 1'b0;
			if (start) begin
				active <= 1'b1;
				issue_cnt <= '0;
				resp_cnt <= '0;
			end else if (active) begin
				if (mem.req && !mem.busy) begin
					issue_cnt <= issue_cnt + 1'b1;
				end
				// Responses come back in issue order
				if (mem.rvalid) begin
					resp_cnt <= resp_cnt + 1'b1;
					ict_write <= 1'b1;
					if (resp_cnt == CNT_W'(IDT_ENTRIES - 1)) begin
						active <= 1'b0;
						done <= 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (start) begin
			base_q <= idtr;
		end
		if (mem.rvalid) begin
			ict.entry <= resp_cnt[5:0];
			ict.mask <= mem.rdata[ICT_MASK_BIT];
			ict.valid <= mem.rdata[ICT_VALID_BIT];
			ict.level <= mem.rdata[ICT_LEVEL_LSB +: 2];
		end
	end

	assert property (@(posedge iCLOCK) disable iff (!inRESET) resp_cnt <= issue_cnt);

endmodule

// File: verilog/ldst_arbiter.sv
// ----------------------------------------------------------
// Owner keeps the port until all its responses are back
// ----------------------------------------------------------
`timescale 1ns/1ps

module ldst_arbiter
	import exc_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	mem_req_if.arbiter clients [NUM_CLIENTS],
	output logic ldst_req,
	input logic ldst_busy,
	output logic ldst_rw,
	output word_t ldst_addr,
	output word_t ldst_data,
	input logic ldst_rvalid,
	input word_t ldst_rdata
);

	logic [NUM_CLIENTS-1:0] req_vec;
	logic [NUM_CLIENTS-1:0] rw_vec;
	word_t addr_vec [NUM_CLIENTS];
	word_t wdata_vec [NUM_CLIENTS];
	logic [NUM_CLIENTS-1:0] grant;
	logic [NUM_CLIENTS-1:0] grant_q;
	logic [CNT_W-1:0] outstanding;
	logic hold;
	logic accept;

	for (genvar i = 0; i < NUM_CLIENTS; i++) begin : g_client
		assign req_vec[i] = clients[i].req;
		assign rw_vec[i] = clients[i].rw;
		assign addr_vec[i] = clients[i].addr;
		assign wdata_vec[i] = clients[i].wdata;
		assign clients[i].busy = grant[i] ? ldst_busy : 1'b1;
		assign clients[i].rvalid = grant[i] & ldst_rvalid;
		assign clients[i].rdata = grant[i] ? ldst_rdata : '0;
	end

	assign hold = (|(grant_q & req_vec)) || (outstanding != '0);
	// Free port goes to the lowest requesting index
	assign grant = hold ? grant_q : (req_vec & (~req_vec + NUM_CLIENTS'(1)));

	assign ldst_req = |(grant & req_vec);
	assign accept = ldst_req && !ldst_busy;

	always_comb begin
		ldst_rw = 1'b0;
		ldst_addr = '0;
		ldst_data = '0;
		for (int k = 0; k < NUM_CLIENTS; k++) begin
			if (grant[k]) begin
				ldst_rw = rw_vec[k];
				ldst_addr = addr_vec[k];
				ldst_data = wdata_vec[k];
			end
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			grant_q <= '0;
			outstanding <= '0;
		end else begin
			grant_q <= grant;
			outstanding <= outstanding + CNT_W'(accept) - CNT_W'(ldst_rvalid);
		end
	end

	// A response always belongs to an accepted request
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		ldst_rvalid |-> outstanding != '0);

endmodule

// File: verilog/exception_manager.sv
// ----------------------------------------------------------
// Inputs are sampled on iCLOCK; one load/store port is shared
// ----------------------------------------------------------
`timescale 1ns/1ps

module exception_manager
	import exc_pkg::*;
(
	input logic iCLOCK,
	input logic inRESET,
	input logic jump,
	input word_t jump_addr,
	input logic irq_ret,
	input logic idt_set,
	input logic irq_req,
	input logic [IRQ_NUM_W-1:0] irq_num,
	input logic irq_lock,
	input word_t spr,
	input word_t tidr,
	input word_t tisr,
	input word_t psr,
	input word_t ppsr,
	input word_t pcr,
	input word_t ppcr_in,
	input word_t idtr,
	output logic pipeline_stop,
	output logic refresh,
	output logic pc_set,
	output word_t pc,
	output logic ppcr_set,
	output word_t ppcr,
	output logic set_irq_mode,
	output logic clr_irq_mode,
	output logic irq_ack,
	output logic spr_write,
	output word_t spr_new,
	output logic ldst_req,
	input logic ldst_busy,
	output logic ldst_rw,
	output word_t ldst_addr,
	output word_t ldst_data,
	input logic ldst_rvalid,
	input word_t ldst_rdata,
	output logic ict_write,
	output logic [5:0] ict_entry,
	output logic ict_mask,
	output logic ict_valid,
	output logic [1:0] ict_level
);

	logic swap_start;
	logic swap_to_kernel;
	logic swap_done;
	word_t swap_spr;
	logic fetch_start;
	logic [IRQ_NUM_W-1:0] fetch_num;
	logic fetch_done;
	word_t fetch_addr;
	logic load_start;
	logic load_done;
	sysreg_snap_t snap;
	ict_rec_t ict_rec;

	mem_req_if mem_link [NUM_CLIENTS] ();

	assign ict_entry = ict_rec.entry;
	assign ict_mask = ict_rec.mask;
	assign ict_valid = ict_rec.valid;
	assign ict_level = ict_rec.level;

	exc_sequencer exc_sequencer_inst (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.jump(jump), .jump_addr(jump_addr), .irq_ret(irq_ret), .idt_set(idt_set),
		.irq_req(irq_req), .irq_num(irq_num), .irq_lock(irq_lock),
		.spr(spr), .tidr(tidr), .tisr(tisr), .psr(psr), .ppsr(ppsr),
		.pcr(pcr), .ppcr_in(ppcr_in), .idtr(idtr),
		.swap_start(swap_start), .swap_to_kernel(swap_to_kernel), .snap(snap),
		.swap_done(swap_done), .swap_spr(swap_spr),
		.fetch_start(fetch_start), .fetch_num(fetch_num),
		.fetch_done(fetch_done), .fetch_addr(fetch_addr),
		.load_start(load_start), .load_done(load_done),
		.pipeline_stop(pipeline_stop), .refresh(refresh), .pc_set(pc_set), .pc(pc),
		.ppcr_set(ppcr_set), .ppcr(ppcr),
		.set_irq_mode(set_irq_mode), .clr_irq_mode(clr_irq_mode), .irq_ack(irq_ack),
		.spr_write(spr_write), .spr_new(spr_new)
	);

	spr_swap spr_swap_inst (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.start(swap_start), .to_kernel(swap_to_kernel),
		.spr(snap.spr), .tidr(snap.tidr), .tisr(snap.tisr),
		.done(swap_done), .new_spr(swap_spr), .mem(mem_link[CLIENT_SPR])
	);

	handler_fetch handler_fetch_inst (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.start(fetch_start), .irq_num(fetch_num), .idtr(snap.idtr),
		.done(fetch_done), .handler(fetch_addr), .mem(mem_link[CLIENT_FETCH])
	);

	idt_loader idt_loader_inst (
		.iCLOCK(iCLOCK), .inRESET(inRESET),
		.start(load_start), .idtr(snap.idtr), .done(load_done),
		.ict_write(ict_write), .ict(ict_rec), .mem(mem_link[CLIENT_IDT])
	);

	ldst_arbiter ldst_arbiter_inst (
		.iCLOCK(iCLOCK), .inRESET(inRESET), .clients(mem_link),
		.ldst_req(ldst_req), .ldst_busy(ldst_busy), .ldst_rw(ldst_rw),
		.ldst_addr(ldst_addr), .ldst_data(ldst_data),
		.ldst_rvalid(ldst_rvalid), .ldst_rdata(ldst_rdata)
	);

endmodule

// File: test/tb_exception_manager.sv
// ----------------------------------------------------------
// Run from the project root; scenarios come from test/
// Memory model answers in order after 1 to 4 cycles
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_exception_manager
	import exc_pkg::*;
();

	localparam int NUM_SCEN = 9;
	localparam int NUM_COLS = 13;
	localparam int TIMEOUT_CYCLES = NUM_SCEN * 400;

	logic iCLOCK;
	logic inRESET;
	logic jump;
	word_t jump_addr;
	logic irq_ret;
	logic idt_set;
	logic irq_req;
	logic [IRQ_NUM_W-1:0] irq_num;
	logic irq_lock;
	word_t spr;
	word_t tidr;
	word_t tisr;
	word_t psr;
	word_t ppsr;
	word_t pcr;
	word_t ppcr_in;
	word_t idtr;
	logic pipeline_stop;
	logic refresh;
	logic pc_set;
	word_t pc;
	logic ppcr_set;
	word_t ppcr;
	logic set_irq_mode;
	logic clr_irq_mode;
	logic irq_ack;
	logic spr_write;
	word_t spr_new;
	logic ldst_req;
	logic ldst_busy = 1'b0;
	logic ldst_rw;
	word_t ldst_addr;
	word_t ldst_data;
	logic ldst_rvalid = 1'b0;
	word_t ldst_rdata = '0;
	logic ict_write;
	logic [5:0] ict_entry;
	logic ict_mask;
	logic ict_valid;
	logic [1:0] ict_level;

	logic [31:0] tdata [NUM_SCEN*NUM_COLS];
	logic [31:0] lfsr_state = 32'h3b0cb833;
	word_t mem_words [word_t];
	word_t wr_addr_q [$];
	word_t wr_data_q [$];
	// Pending responses as {due cycle, data}
	logic [63:0] rsp_q [$];
	int last_due = 0;
	int cycle_cnt = 0;
	int fail_cnt = 0;

	exception_manager exception_manager_inst (.*);

	initial begin
		iCLOCK = 1'b0;
		forever #4 iCLOCK = ~iCLOCK;
	end

	// Taps 32, 22, 2, 1
	function automatic logic take_bit();
		lfsr_state = {lfsr_state[30:0],
			lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
		return lfsr_state[0];
	endfunction

	function automatic word_t read_word(input word_t addr);
		if (mem_words.exists(addr)) begin
			return mem_words[addr];
		end
		return addr ^ 32'h5a5a0000;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			fail_cnt++;
			$display("FAIL at %0d ns: %s = %h, expected %h", $time, name, actual, expected);
			$display("Some tests failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	always @(posedge iCLOCK) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("ERROR: no progress after %0d cycles, the DUT seems stuck", cycle_cnt);
			$display("Some tests failed");
			$fatal(1, "run stopped by timeout");
		end
	end

	// Load/store memory with random busy and in-order responses
	always @(posedge iCLOCK or negedge inRESET) begin : mem_model
		word_t rsp;
		int due;
		logic [63:0] head;
		if (!inRESET) begin
			ldst_busy <= 1'b0;
			ldst_rvalid <= 1'b0;
			ldst_rdata <= '0;
			rsp_q.delete();
		end else begin
			ldst_rvalid <= 1'b0;
			if (rsp_q.size() > 0 && rsp_q[0][63:32] == cycle_cnt) begin
				head = rsp_q.pop_front();
				ldst_rvalid <= 1'b1;
				ldst_rdata <= head[31:0];
			end
			if (ldst_req && !ldst_busy) begin
				due = cycle_cnt + 1 + int'({take_bit(), take_bit()});
				if (due <= last_due) begin
					due = last_due + 1;
				end
				last_due = due;
				if (ldst_rw) begin
					mem_words[ldst_addr] = ldst_data;
					wr_addr_q.push_back(ldst_addr);
					wr_data_q.push_back(ldst_data);
					rsp = '0;
				end else begin
					rsp = read_word(ldst_addr);
				end
				rsp_q.push_back({due[31:0], rsp});
			end
			ldst_busy <= take_bit() & take_bit();
		end
	end

	task automatic run_scenario(input int idx);
		logic [31:0] f [NUM_COLS];
		int kind;
		int waited;
		int spr_writes;
		int ppcr_sets;
		int ict_count;
		logic swap_expected;
		logic irq_kind;
		logic pc_seen;
		word_t block;
		word_t exp_word;
		for (int c = 0; c < NUM_COLS; c++) begin
			f[c] = tdata[idx*NUM_COLS + c];
		end
		kind = int'(f[0]);
		irq_kind = (kind == 1) || (kind == 4);
		if (kind == 2) begin
			swap_expected = f[3][PSR_MODE_LSB +: 2] == USER;
		end else begin
			swap_expected = irq_kind && (f[2][PSR_MODE_LSB +: 2] == USER);
		end
		block = f[8] + (word_t'(f[7][13:0]) << TST_BLOCK_SHIFT);
		spr_writes = 0;
		ppcr_sets = 0;
		ict_count = 0;
		pc_seen = 1'b0;
		waited = 0;

		@(posedge iCLOCK);
		irq_num <= f[1][IRQ_NUM_W-1:0];
		psr <= f[2];
		ppsr <= f[3];
		pcr <= f[4];
		ppcr_in <= f[5];
		spr <= f[6];
		tidr <= f[7];
		tisr <= f[8];
		idtr <= f[9];
		jump_addr <= f[10];
		@(posedge iCLOCK);
		wr_addr_q.delete();
		wr_data_q.delete();
		jump <= (kind == 0) || (kind == 4);
		irq_req <= irq_kind;
		irq_ret <= (kind == 2);
		idt_set <= (kind == 3);
		@(posedge iCLOCK);
		jump <= 1'b0;
		irq_req <= 1'b0;
		irq_ret <= 1'b0;
		idt_set <= 1'b0;
		if (kind == 1) begin
			check_value("pipeline_stop", pipeline_stop, 1'b1);
		end

		while (!pc_seen) begin
			@(posedge iCLOCK);
			waited++;
			if (waited == 1) begin
				check_value("refresh", refresh, 1'b1);
			end
			if (kind == 0) begin
				check_value("ldst_req", ldst_req, 1'b0);
			end
			if (ppcr_set) begin
				ppcr_sets++;
				check_value("set_irq_mode", set_irq_mode, 1'b1);
				check_value("ppcr", ppcr, (kind == 4) ? f[10] : f[4]);
				if (kind == 1) begin
					check_value("ppcr_set latency", waited, 1);
				end
			end
			if (spr_write) begin
				spr_writes++;
				check_value("spr_new", spr_new, f[12]);
				check_value("pc_set", pc_set, 1'b0);
			end
			if (ict_write) begin
				// Entry word 0 holds valid in bit 0, mask in bit 1 and level in bits 17:16
				exp_word = read_word(f[9] + word_t'(ict_count * IDT_STRIDE));
				check_value("ict_entry", ict_entry, ict_count);
				check_value("ict_valid", ict_valid, exp_word[0]);
				check_value("ict_mask", ict_mask, exp_word[1]);
				check_value("ict_level", ict_level, exp_word[17:16]);
				ict_count++;
			end
			if (pc_set) begin
				pc_seen = 1'b1;
				check_value("pc", pc, f[11]);
				check_value("irq_ack", irq_ack, irq_kind);
				check_value("clr_irq_mode", clr_irq_mode, kind == 2);
				if (kind == 0) begin
					check_value("pc_set latency", waited, 2);
				end
			end else begin
				check_value("pipeline_stop", pipeline_stop, 1'b1);
			end
		end

		check_value("spr_write count", spr_writes, swap_expected);
		check_value("ppcr_set count", ppcr_sets, irq_kind);
		check_value("ict_write count", ict_count, (kind == 3) ? IDT_ENTRIES : 0);
		if (swap_expected) begin
			// Outgoing SPR lands in the slot of the mode being left
			check_value("write count", wr_addr_q.size(), 1);
			check_value("write addr", wr_addr_q[0],
				block + word_t'((kind == 2) ? TST_KSPR_OFFSET : TST_USPR_OFFSET));
			check_value("write data", wr_data_q[0], f[6]);
		end else begin
			check_value("write count", wr_addr_q.size(), 0);
		end
	endtask

	initial begin
		inRESET = 1'b0;
		jump = 1'b0;
		jump_addr = '0;
		irq_ret = 1'b0;
		idt_set = 1'b0;
		irq_req = 1'b0;
		irq_num = '0;
		irq_lock = 1'b0;
		spr = '0;
		tidr = '0;
		tisr = '0;
		psr = '0;
		ppsr = '0;
		pcr = '0;
		ppcr_in = '0;
		idtr = '0;
		$readmemh("test/exc_testdata.txt", tdata);
		for (int s = 0; s < NUM_SCEN; s++) begin
			if ($isunknown(tdata[s*NUM_COLS]) || $isunknown(tdata[s*NUM_COLS + NUM_COLS - 1])) begin
				$display("ERROR: test data file has no complete line for scenario %0d", s);
				$display("Some tests failed");
				$fatal(1, "test data incomplete");
			end
		end

		repeat (15) @(posedge iCLOCK);
		check_value("pc_set", pc_set, 1'b0);
		check_value("ppcr_set", ppcr_set, 1'b0);
		check_value("set_irq_mode", set_irq_mode, 1'b0);
		check_value("clr_irq_mode", clr_irq_mode, 1'b0);
		check_value("irq_ack", irq_ack, 1'b0);
		check_value("spr_write", spr_write, 1'b0);
		check_value("ict_write", ict_write, 1'b0);
		check_value("refresh", refresh, 1'b0);
		check_value("ldst_req", ldst_req, 1'b0);
		@(posedge iCLOCK);
		inRESET <= 1'b1;

		for (int s = 0; s < NUM_SCEN; s++) begin
			run_scenario(s);
		end

		if (fail_cnt == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("Some tests failed");
			$fatal(1, "checks failed");
		end
	end

endmodule

// File: test/exc_testdata.txt
// kind irq_num psr ppsr pcr ppcr spr tidr tisr idtr jump_addr exp_pc exp_spr (hex)
// kind 0 branch, 1 interrupt, 2 return, 3 IDT set, 4 branch with pending interrupt
0 00 00000000 00000000 00001000 00000000 00000000 00000000 00000000 00000000 00004000 00004000 00000000
1 05 00000004 00000000 00001234 00000000 00050000 00000000 00100000 00008000 00000000 5a5a802c 00000000
1 11 00000064 00000000 00001238 00000000 0007fff0 00000005 00100000 00008000 00000000 5a5a808c 5a4a050c
2 00 00000000 00000060 00000000 00002222 00090000 00000005 00100000 00008000 00000000 00002222 0007fff0
2 00 00000000 00000000 00000000 00003330 00090000 00000005 00100000 00008000 00000000 00003330 00000000
3 00 00000000 00000000 00000000 00000000 00000000 00000000 00000000 0002ff03 00005000 00005000 00000000
3 00 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00010000 00006004 00006004 00000000
4 03 00000004 00000000 00001000 00000000 00050000 00000000 00100000 00008000 00007000 5a5a801c 00000000
4 09 00000064 00000000 00001000 00000000 00060000 00004007 00100000 00008000 00007100 5a5a804c 5a4a070c

// File: verilog.f
verilog/exc_pkg.sv
verilog/mem_req_if.sv
verilog/exc_sequencer.sv
verilog/handler_fetch.sv
verilog/spr_swap.sv
verilog/idt_loader.sv
verilog/ldst_arbiter.sv
verilog/exception_manager.sv
test/tb_exception_manager.sv
